/* hdl/coreplex_settings.svh */
/*
 * Address map and bus widths of the coreplex memory fabric.
 * Include this in any file that needs a region base, a region width or the data width.
 */
`ifndef COREPLEX_SETTINGS_SVH
`define COREPLEX_SETTINGS_SVH

// Bus widths
`define CP_XLEN         32              // Data and address width
`define CP_NB_BYTES     4               // Byte lanes per word

// Tightly coupled memory, 256 words
`define CP_TCM_BASE     32'h8000_0000
`define CP_TCM_AWIDTH   10              // Byte address LSBs inside region

// Scratch memory, 64 words in the low region
`define CP_SCR_BASE     32'h0000_0000
`define CP_SCR_AWIDTH   8

// Peripheral data bus window
`define CP_PD_BASE      32'h1000_0000
`define CP_PD_AWIDTH    28

`endif

/* hdl/coreplex_pkg.sv */
/*
 * Request, response and peripheral command structs of the coreplex buses.
 * RTL files refer to these by scoped names.
 */
`include "coreplex_settings.svh"

package coreplex_pkg;

    // --------------------------------------------------
    // Core side requests
    // --------------------------------------------------
    typedef struct packed {
        logic                    req;       // Fetch strobe
        logic [`CP_XLEN-1:0]     addr;      // Word aligned fetch address
    } instr_req_t;

    typedef struct packed {
        logic                    req;
        logic                    we;        // 1 = store
        logic [`CP_NB_BYTES-1:0] be;        // Byte enables
        logic [`CP_XLEN-1:0]     addr;
        logic [`CP_XLEN-1:0]     wdata;
    } data_req_t;

    // --------------------------------------------------
    // Core side responses
    // --------------------------------------------------
    typedef struct packed {
        logic                gnt;
        logic                rvalid;        // One cycle pulse per granted item
        logic [`CP_XLEN-1:0] rdata;         // Zero while rvalid low
    } instr_rsp_t;

    typedef struct packed {
        logic                gnt;
        logic                rvalid;
        logic [`CP_XLEN-1:0] rdata;
        logic                err;
    } data_rsp_t;

    // Peripheral data ICB command
    typedef struct packed {
        logic                    read;      // 1 = load, 0 = store
        logic [`CP_XLEN-1:0]     addr;
        logic [`CP_XLEN-1:0]     wdata;
        logic [`CP_NB_BYTES-1:0] wmask;
    } icb_cmd_t;

endpackage : coreplex_pkg

/* hdl/scratch_ram.sv */
/*
 * Single-port scratch memory with byte writes and a registered read.
 */
`include "coreplex_settings.svh"

module scratch_ram #(
    parameter int AWIDTH = 6                 // Word address bits
) (
    input  logic                    clk,
    input  logic                    en_i,
    input  logic                    we_i,
    input  logic [`CP_NB_BYTES-1:0] be_i,
    input  logic [AWIDTH-1:0]       addr_i,
    input  logic [`CP_XLEN-1:0]     wdata_i,
    output logic [`CP_XLEN-1:0]     rdata_o
);

    logic [`CP_NB_BYTES-1:0][7:0] mem [2**AWIDTH];

    // Read first, old word shows on a write cycle
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= mem[addr_i];
            if (we_i) begin
                for (int b = 0; b < `CP_NB_BYTES; b++) begin
                    if (be_i[b]) begin
                        mem[addr_i][b] <= wdata_i[8*b +: 8];   // Enabled lanes only
                    end
                end
            end
        end
    end

endmodule : scratch_ram

/* hdl/tcm_ram.sv */
/*
 * Dual-port tightly coupled memory. Port A serves instruction fetches and port B serves data.
 * Requests in the region are granted at once, and read data follows one cycle later.
 */
`include "coreplex_settings.svh"

module tcm_ram #(
    parameter logic [`CP_XLEN-1:0] ADDR_BASE   = `CP_TCM_BASE,
    parameter int                  ADDR_AWIDTH = `CP_TCM_AWIDTH
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  coreplex_pkg::instr_req_t instr_req_i,
    output coreplex_pkg::instr_rsp_t instr_rsp_o,
    input  coreplex_pkg::data_req_t  data_req_i,
    output coreplex_pkg::data_rsp_t  data_rsp_o
);

    localparam int                  WAW   = ADDR_AWIDTH - 2;           // Word index width
    localparam int                  DEPTH = 2 ** WAW;
    localparam logic [`CP_XLEN-1:0] MASK  = {ADDR_AWIDTH{1'b1}};

    logic instr_cs, data_cs;                 // Region hits
    logic instr_rvalid_q, data_rvalid_q;
    logic [WAW-1:0] instr_idx, data_idx;
    logic [`CP_XLEN-1:0] instr_rdata_q, data_rdata_q;

    // Byte lane array
    logic [`CP_NB_BYTES-1:0][7:0] mem [DEPTH];

    // --------------------------------------------------
    // Decode and grant
    // --------------------------------------------------
    assign instr_cs = instr_req_i.req &
                      ((instr_req_i.addr & ~MASK) == (ADDR_BASE & ~MASK));
    assign data_cs  = data_req_i.req &
                      ((data_req_i.addr & ~MASK) == (ADDR_BASE & ~MASK));

    assign instr_idx = instr_req_i.addr[ADDR_AWIDTH-1:2];
    assign data_idx  = data_req_i.addr[ADDR_AWIDTH-1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_cs;      // Fixed one cycle latency
            data_rvalid_q  <= data_cs;
        end
    end

    // Port A, read only
    always_ff @(posedge clk) begin
        if (instr_cs) begin
            instr_rdata_q <= mem[instr_idx];
        end
    end

    // Port B, read first with byte writes
    always_ff @(posedge clk) begin
        if (data_cs) begin
            data_rdata_q <= mem[data_idx];
            for (int b = 0; b < `CP_NB_BYTES; b++) begin
                if (data_req_i.we && data_req_i.be[b]) begin
                    mem[data_idx][b] <= data_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // Responses
    // --------------------------------------------------
    assign instr_rsp_o.gnt    = instr_cs;
    assign instr_rsp_o.rvalid = instr_rvalid_q;
    assign instr_rsp_o.rdata  = instr_rvalid_q ? instr_rdata_q : '0;

    assign data_rsp_o.gnt    = data_cs;
    assign data_rsp_o.rvalid = data_rvalid_q;
    assign data_rsp_o.rdata  = data_rvalid_q ? data_rdata_q : '0;
    assign data_rsp_o.err    = 1'b0;         // Never faults

endmodule : tcm_ram

/* hdl/scratch_arbiter.sv */
/*
 * Round-robin sharing of the single scratch memory port by the instruction and data buses.
 * The selected requester is granted in the same cycle and gets its data one cycle later.
 */
`include "coreplex_settings.svh"

module scratch_arbiter #(
    parameter logic [`CP_XLEN-1:0] ADDR_BASE   = `CP_SCR_BASE,
    parameter int                  ADDR_AWIDTH = `CP_SCR_AWIDTH
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  coreplex_pkg::instr_req_t instr_req_i,
    output coreplex_pkg::instr_rsp_t instr_rsp_o,
    input  coreplex_pkg::data_req_t  data_req_i,
    output coreplex_pkg::data_rsp_t  data_rsp_o
);

    localparam int                  WAW  = ADDR_AWIDTH - 2;
    localparam logic [`CP_XLEN-1:0] MASK = {ADDR_AWIDTH{1'b1}};

    logic instr_cs, data_cs;
    logic instr_sel_q;                       // 1 = instruction side owns the port
    logic instr_gnt, data_gnt;
    logic instr_rvalid_q, data_rvalid_q;
    logic ram_en, ram_we;
    logic [`CP_NB_BYTES-1:0] ram_be;
    logic [WAW-1:0] ram_addr;
    logic [`CP_XLEN-1:0] ram_rdata;

    assign instr_cs = instr_req_i.req &
                      ((instr_req_i.addr & ~MASK) == (ADDR_BASE & ~MASK));
    assign data_cs  = data_req_i.req &
                      ((data_req_i.addr & ~MASK) == (ADDR_BASE & ~MASK));

    assign instr_gnt = instr_cs &  instr_sel_q;
    assign data_gnt  = data_cs  & ~instr_sel_q;

    // --------------------------------------------------
    // Select register and rvalid pipeline
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_sel_q    <= 1'b1;          // Fetches first after reset
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
        end else begin
            if (instr_cs && data_cs) begin
                instr_sel_q <= ~instr_sel_q; // Both asking, alternate
            end else if (instr_cs || data_cs) begin
                instr_sel_q <= instr_cs;     // Move to lone requester
            end
            instr_rvalid_q <= instr_gnt;
            data_rvalid_q  <= data_gnt;
        end
    end

    // Port mux, fetches are full word reads
    assign ram_en   = instr_gnt | data_gnt;
    assign ram_we   = data_req_i.we & ~instr_sel_q;
    assign ram_be   = data_req_i.be | {`CP_NB_BYTES{instr_sel_q}};
    assign ram_addr = instr_sel_q ? instr_req_i.addr[ADDR_AWIDTH-1:2]
                                  : data_req_i.addr[ADDR_AWIDTH-1:2];

    scratch_ram #(
        .AWIDTH (WAW)
    ) u_scratch_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .be_i    (ram_be),
        .addr_i  (ram_addr),
        .wdata_i (data_req_i.wdata),
        .rdata_o (ram_rdata)
    );

    // Steer read data to last cycle's winner
    assign instr_rsp_o.gnt    = instr_gnt;
    assign instr_rsp_o.rvalid = instr_rvalid_q;
    assign instr_rsp_o.rdata  = instr_rvalid_q ? ram_rdata : '0;

    assign data_rsp_o.gnt    = data_gnt;
    assign data_rsp_o.rvalid = data_rvalid_q;
    assign data_rsp_o.rdata  = data_rvalid_q ? ram_rdata : '0;
    assign data_rsp_o.err    = 1'b0;

endmodule : scratch_arbiter

/* hdl/pd_icb_bridge.sv */
/*
 * Bridge from core data requests to the peripheral data ICB.
 * The command is combinational from the request, and the response comes back one cycle later.
 */
`include "coreplex_settings.svh"

module pd_icb_bridge #(
    parameter logic [`CP_XLEN-1:0] ADDR_BASE   = `CP_PD_BASE,
    parameter int                  ADDR_AWIDTH = `CP_PD_AWIDTH
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  coreplex_pkg::data_req_t  data_req_i,
    output coreplex_pkg::data_rsp_t  data_rsp_o,
    output logic                    cmd_valid_o,
    input  logic                    cmd_ready_i,
    output coreplex_pkg::icb_cmd_t   cmd_o,
    input  logic                    rsp_valid_i,
    output logic                    rsp_ready_o,
    input  logic [`CP_XLEN-1:0]     rsp_rdata_i
);

    localparam logic [`CP_XLEN-1:0] MASK = {ADDR_AWIDTH{1'b1}};

    logic rsp_fire;
    logic rvalid_q;
    logic [`CP_XLEN-1:0] rdata_q;

    // Command mirrors the request while in region
    assign cmd_valid_o = data_req_i.req &
                         ((data_req_i.addr & ~MASK) == (ADDR_BASE & ~MASK));
    assign cmd_o.read  = ~data_req_i.we;
    assign cmd_o.addr  = data_req_i.addr;
    assign cmd_o.wdata = data_req_i.wdata;
    assign cmd_o.wmask = data_req_i.be;

    assign rsp_ready_o = 1'b1;               // Core always takes the response
    assign rsp_fire    = rsp_valid_i & rsp_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rsp_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            rdata_q <= rsp_rdata_i;
        end
    end

    assign data_rsp_o.gnt    = cmd_valid_o & cmd_ready_i;   // Held off by cmd_ready
    assign data_rsp_o.rvalid = rvalid_q;
    assign data_rsp_o.rdata  = rvalid_q ? rdata_q : '0;
    assign data_rsp_o.err    = 1'b0;

endmodule : pd_icb_bridge

/* hdl/rsp_merge.sv */
/*
 * Merges the responses of all targets on one bus.
 * Flags are ORed together, and each target's rdata is masked by its own rvalid before the OR.
 */
module rsp_merge #(
    parameter type rsp_t = coreplex_pkg::data_rsp_t,
    parameter int  N     = 2                 // Number of targets
) (
    input  rsp_t [N-1:0] rsp_i,
    output rsp_t         rsp_o
);

    // --------------------------------------------------
    // Masked OR over targets
    // --------------------------------------------------
    always_comb begin
        rsp_t acc;
        rsp_t cur;
        acc = '0;
        for (int k = 0; k < N; k++) begin
            cur = rsp_i[k];
            if (!cur.rvalid) begin
                cur.rdata = '0;              // Idle target adds nothing
            end
            acc = rsp_t'(acc | cur);         // gnt, rvalid, err and rdata together
        end
        rsp_o = acc;
    end

endmodule : rsp_merge

/* hdl/coreplex_top.sv */
/*
 * Memory side of the coreplex. It takes the core's instruction and data buses and routes them
 * to the tightly coupled memory, the scratch memory and the peripheral data ICB.
 */
`include "coreplex_settings.svh"

module coreplex_top (
    input  logic                     clk,
    input  logic                     rst_n,

    // Core instruction bus
    input  coreplex_pkg::instr_req_t instr_req_i,
    output coreplex_pkg::instr_rsp_t instr_rsp_o,

    // Core data bus
    input  coreplex_pkg::data_req_t  data_req_i,
    output coreplex_pkg::data_rsp_t  data_rsp_o,

    // Peripheral data ICB
    output logic                     pd_cmd_valid_o,
    input  logic                     pd_cmd_ready_i,
    output coreplex_pkg::icb_cmd_t   pd_cmd_o,
    input  logic                     pd_rsp_valid_i,
    output logic                     pd_rsp_ready_o,
    input  logic [`CP_XLEN-1:0]      pd_rsp_rdata_i
);

    // Per target responses
    coreplex_pkg::instr_rsp_t tcm_instr_rsp, scr_instr_rsp;
    coreplex_pkg::data_rsp_t  tcm_data_rsp, scr_data_rsp, pd_data_rsp;

    // --------------------------------------------------
    // Targets
    // --------------------------------------------------
    tcm_ram #(
        .ADDR_BASE   (`CP_TCM_BASE),
        .ADDR_AWIDTH (`CP_TCM_AWIDTH)
    ) u_tcm (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_req_i (instr_req_i),
        .instr_rsp_o (tcm_instr_rsp),
        .data_req_i  (data_req_i),
        .data_rsp_o  (tcm_data_rsp)
    );

    scratch_arbiter #(
        .ADDR_BASE   (`CP_SCR_BASE),
        .ADDR_AWIDTH (`CP_SCR_AWIDTH)
    ) u_scratch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_req_i (instr_req_i),
        .instr_rsp_o (scr_instr_rsp),
        .data_req_i  (data_req_i),
        .data_rsp_o  (scr_data_rsp)
    );

    pd_icb_bridge #(
        .ADDR_BASE   (`CP_PD_BASE),
        .ADDR_AWIDTH (`CP_PD_AWIDTH)
    ) u_pd_bridge (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_req_i  (data_req_i),
        .data_rsp_o  (pd_data_rsp),
        .cmd_valid_o (pd_cmd_valid_o),
        .cmd_ready_i (pd_cmd_ready_i),
        .cmd_o       (pd_cmd_o),
        .rsp_valid_i (pd_rsp_valid_i),
        .rsp_ready_o (pd_rsp_ready_o),
        .rsp_rdata_i (pd_rsp_rdata_i)
    );

    // --------------------------------------------------
    // Response aggregation per bus
    // --------------------------------------------------
    rsp_merge #(
        .rsp_t (coreplex_pkg::instr_rsp_t),
        .N     (2)
    ) u_instr_merge (
        .rsp_i ({tcm_instr_rsp, scr_instr_rsp}),
        .rsp_o (instr_rsp_o)
    );

    rsp_merge #(
        .rsp_t (coreplex_pkg::data_rsp_t),
        .N     (3)
    ) u_data_merge (
        .rsp_i ({tcm_data_rsp, scr_data_rsp, pd_data_rsp}),
        .rsp_o (data_rsp_o)
    );

endmodule : coreplex_top

/* tb/coreplex_chk.sv */
/*
 * Bus protocol assertions for coreplex_top, attached to the top level with bind.
 * fail_cnt holds the number of failed assertions.
 */
module coreplex_chk (
    input  logic                     clk,
    input  logic                     rst_n,
    input  coreplex_pkg::instr_rsp_t instr_rsp_i,
    input  coreplex_pkg::data_rsp_t  data_rsp_i,
    input  logic                     pd_cmd_valid_i,
    input  logic                     pd_cmd_ready_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;                            // Failed assertions so far

    // Fetch data one cycle after its grant
    a_instr_lat : assert property (@(posedge clk) disable iff (!rst_n)
        instr_rsp_i.gnt |=> instr_rsp_i.rvalid)
        else begin
            $error("instruction rvalid missing one cycle after gnt");
            fail_cnt++;
        end

    // Back pressure from the peripheral blocks the data grant
    a_pd_hold : assert property (@(posedge clk) disable iff (!rst_n)
        !(pd_cmd_valid_i && !pd_cmd_ready_i && data_rsp_i.gnt))
        else begin
            $error("data gnt while peripheral command not ready");
            fail_cnt++;
        end

    a_rdata_idle : assert property (@(posedge clk) disable iff (!rst_n)
        (instr_rsp_i.rvalid || instr_rsp_i.rdata == '0) &&
        (data_rsp_i.rvalid || data_rsp_i.rdata == '0))
        else begin
            $error("rdata not zero while rvalid low");
            fail_cnt++;
        end

endmodule : coreplex_chk

bind coreplex_top coreplex_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_rsp_i    (instr_rsp_o),
    .data_rsp_i     (data_rsp_o),
    .pd_cmd_valid_i (pd_cmd_valid_o),
    .pd_cmd_ready_i (pd_cmd_ready_i)
);

/* tb/coreplex_tb.sv */
/*
 * Directed testbench for the coreplex memory fabric. It acts as the core on both buses,
 * answers peripheral commands and checks each response against its own memory model.
 */
`include "coreplex_settings.svh"

module coreplex_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE        = 4;
    localparam int RESET_CYCLES = 16;
    localparam int N_TCM        = 24;                    // TCM test words, 10 apart
    localparam int N_SCR        = 8;                     // Scratch test words, 8 apart
    localparam int N_PD         = 4;
    // Each bus item of the tests gets 16 cycles
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 16 * (4 * N_TCM + 3 * N_SCR + N_PD);

    logic                     clk, rst_n;
    coreplex_pkg::instr_req_t instr_req;
    coreplex_pkg::instr_rsp_t instr_rsp;
    coreplex_pkg::data_req_t  data_req;
    coreplex_pkg::data_rsp_t  data_rsp;
    coreplex_pkg::icb_cmd_t   pd_cmd;
    logic                     pd_cmd_valid, pd_cmd_ready, pd_rsp_valid, pd_rsp_ready;
    logic [`CP_XLEN-1:0]      pd_rsp_rdata;

    int          seed;
    int          value_errors, other_errors;
    logic [31:0] tcm_model [N_TCM];                      // Expected word per test address
    logic [31:0] scr_model [N_SCR];
    logic        scr_log;                                // Log scratch grant order
    logic        scr_order [$];                          // 1 = instruction bus won

    coreplex_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_req_i    (instr_req),
        .instr_rsp_o    (instr_rsp),
        .data_req_i     (data_req),
        .data_rsp_o     (data_rsp),
        .pd_cmd_valid_o (pd_cmd_valid),
        .pd_cmd_ready_i (pd_cmd_ready),
        .pd_cmd_o       (pd_cmd),
        .pd_rsp_valid_i (pd_rsp_valid),
        .pd_rsp_ready_o (pd_rsp_ready),
        .pd_rsp_rdata_i (pd_rsp_rdata)
    );

    always #(CYCLE / 2) clk = ~clk;

    // ---- Reporting and model helpers ---------------
    task automatic report_mismatch(input string name, input logic [127:0] got, exp);
        $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        value_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        other_errors++;
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, new_w,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];         // Enabled lane takes new byte
            end
        end
        return res;
    endfunction

    // ---- Core side drivers -------------------------
    // Request held until gnt, then rvalid awaited; both waits counted in cycles
    task automatic instr_fetch(input logic [31:0] addr, output logic [31:0] rdata,
                               output int gnt_wait, output int lat);
        @(posedge clk);
        #1;
        instr_req = '{req: 1'b1, addr: addr};
        gnt_wait  = 0;
        @(negedge clk);
        while (!instr_rsp.gnt) begin
            gnt_wait++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        instr_req = '0;                                  // Granted, drop it
        lat = 1;
        @(negedge clk);
        while (!instr_rsp.rvalid) begin
            lat++;
            @(negedge clk);
        end
        rdata = instr_rsp.rdata;
    endtask

    task automatic data_access(input logic we, input logic [3:0] be,
                               input logic [31:0] addr, wdata,
                               output logic [31:0] rdata, output int gnt_wait, output int lat);
        @(posedge clk);
        #1;
        data_req = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
        gnt_wait = 0;
        @(negedge clk);
        while (!data_rsp.gnt) begin
            gnt_wait++;                                  // Arbiter or peripheral stall
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        data_req = '0;
        lat = 1;
        @(negedge clk);
        while (!data_rsp.rvalid) begin
            lat++;
            @(negedge clk);
        end
        rdata = data_rsp.rdata;
        if (data_rsp.err !== 1'b0) begin
            report_mismatch("data_rsp_o.err", data_rsp.err, 0);
        end
    endtask

    // ---- Tests -------------------------------------
    task automatic idle_after_reset();
        logic [4:0] flags;
        repeat (2) @(negedge clk);
        flags = {instr_rsp.gnt, instr_rsp.rvalid, data_rsp.gnt, data_rsp.rvalid, pd_cmd_valid};
        if (flags !== 5'b0) begin
            report_mismatch("gnt, rvalid and pd_cmd_valid_o after reset", flags, 0);
        end
    endtask

    task automatic tcm_write_readback();
        logic [31:0] addr, wdata, rdata;
        logic [3:0]  be;
        int          gnt_wait, lat;
        for (int i = 0; i < N_TCM; i++) begin
            addr  = `CP_TCM_BASE + 32'(40 * i);
            wdata = $random(seed);
            data_access(1'b1, 4'hF, addr, wdata, rdata, gnt_wait, lat);   // Full word first
            tcm_model[i] = wdata;
            wdata = $random(seed);
            be    = 4'($random(seed));
            data_access(1'b1, be, addr, wdata, rdata, gnt_wait, lat);
            tcm_model[i] = merge_bytes(tcm_model[i], wdata, be);
            data_access(1'b0, 4'hF, addr, '0, rdata, gnt_wait, lat);
            if (rdata !== tcm_model[i]) begin
                report_mismatch("data_rsp_o.rdata", rdata, tcm_model[i]);
            end
            if (gnt_wait != 0 || lat != 1) begin
                report_problem("TCM data read not granted at once with rvalid one cycle later");
            end
        end
    endtask

    task automatic tcm_fetch_readback();
        logic [31:0] rdata;
        int          gnt_wait, lat;
        for (int i = 0; i < N_TCM; i++) begin
            instr_fetch(`CP_TCM_BASE + 32'(40 * i), rdata, gnt_wait, lat);
            if (rdata !== tcm_model[i]) begin
                report_mismatch("instr_rsp_o.rdata", rdata, tcm_model[i]);
            end
            if (gnt_wait != 0 || lat != 1) begin
                report_problem("TCM fetch not granted at once with rvalid one cycle later");
            end
        end
    endtask

    task automatic scratch_round_robin();
        logic [31:0] rdata, rd_i, rd_d;
        int          gnt_wait, lat, n_instr, gw_i, lt_i, gw_d, lt_d, j;
        logic        instr_won, prev_won;
        for (int i = 0; i < N_SCR; i++) begin
            scr_model[i] = $random(seed);
            data_access(1'b1, 4'hF, `CP_SCR_BASE + 32'(32 * i), scr_model[i], rdata,
                        gnt_wait, lat);
        end
        scr_order.delete();
        scr_log  = 1'b1;
        prev_won = 1'b0;
        // Both buses ask in the same cycle each round
        for (int i = 0; i < N_SCR; i++) begin
            j = N_SCR - 1 - i;                           // Loads walk down for variety
            fork
                instr_fetch(`CP_SCR_BASE + 32'(32 * i), rd_i, gw_i, lt_i);
                data_access(1'b0, 4'hF, `CP_SCR_BASE + 32'(32 * j), '0, rd_d, gw_d, lt_d);
            join
            if (rd_i !== scr_model[i]) begin
                report_mismatch("instr_rsp_o.rdata", rd_i, scr_model[i]);
            end
            if (rd_d !== scr_model[j]) begin
                report_mismatch("data_rsp_o.rdata", rd_d, scr_model[j]);
            end
            if (lt_i != 1 || lt_d != 1) begin
                report_problem("scratch rvalid not one cycle after gnt");
            end
            if (gw_i + gw_d != 1) begin
                report_problem("scratch did not grant one bus at once and the other next");
            end
            instr_won = (gw_i == 0);
            if (i > 0 && instr_won == prev_won) begin
                report_problem("scratch round winner did not alternate between the buses");
            end
            prev_won = instr_won;
        end
        scr_log = 1'b0;
        n_instr = 0;
        foreach (scr_order[k]) begin
            n_instr += scr_order[k];
        end
        if (scr_order.size() != 2 * N_SCR || n_instr != N_SCR) begin
            report_problem("scratch grant count differs from one grant per item");
        end
    endtask

    task automatic pd_bridge_access();
        coreplex_pkg::icb_cmd_t exp_cmd;
        logic [31:0] addr, wdata, rdata, exp_rdata;
        logic [3:0]  be;
        int          gnt_wait, lat;
        for (int i = 0; i < N_PD; i++) begin
            addr      = `CP_PD_BASE | (32'($random(seed)) & 32'h0FFF_FFFC);
            wdata     = $random(seed);
            be        = i[0] ? 4'hF : 4'($random(seed));  // Odd items are loads
            exp_cmd   = '{read: i[0], addr: addr, wdata: wdata, wmask: be};
            exp_rdata = ~addr;
            fork
                data_access(~i[0], be, addr, wdata, rdata, gnt_wait, lat);
                begin
                    @(negedge clk);
                    while (!pd_cmd_valid) begin
                        @(negedge clk);
                    end
                    if (pd_cmd !== exp_cmd) begin
                        report_mismatch("pd_cmd_o", pd_cmd, exp_cmd);
                    end
                end
            join
            if (rdata !== exp_rdata) begin
                report_mismatch("data_rsp_o.rdata", rdata, exp_rdata);
            end
        end
    endtask

    // ---- Peripheral responder ----------------------
    // cmd_ready low for 0 to 3 cycles, then the inverted address comes back
    always begin : pd_responder
        int          delay;
        logic [31:0] cmd_addr;
        @(negedge clk);
        if (pd_cmd_valid) begin
            delay = $unsigned($random(seed)) % 4;
            repeat (delay) @(negedge clk);
            @(posedge clk);
            #1;
            pd_cmd_ready = 1'b1;
            cmd_addr     = pd_cmd.addr;
            @(posedge clk);
            #1;                                          // Command taken at that edge
            pd_cmd_ready = 1'b0;
            pd_rsp_valid = 1'b1;
            pd_rsp_rdata = ~cmd_addr;
            @(posedge clk);
            #1;
            pd_rsp_valid = 1'b0;
            pd_rsp_rdata = '0;
        end
    end

    // Bus checks on every cycle, plus the scratch grant log
    always @(negedge clk) begin : bus_monitor
        if (rst_n) begin
            if (pd_cmd_valid && !pd_cmd_ready && data_rsp.gnt) begin
                report_problem("data gnt given while the peripheral held off the command");
            end
            if (pd_rsp_ready !== 1'b1) begin
                report_mismatch("pd_rsp_ready_o", pd_rsp_ready, 1);
            end
            if (!instr_rsp.rvalid && instr_rsp.rdata !== '0) begin
                report_mismatch("instr_rsp_o.rdata", instr_rsp.rdata, 0);
            end
            if (!data_rsp.rvalid && data_rsp.rdata !== '0) begin
                report_mismatch("data_rsp_o.rdata", data_rsp.rdata, 0);
            end
            if (scr_log && instr_rsp.gnt) begin
                scr_order.push_back(1'b1);
            end
            if (scr_log && data_rsp.gnt) begin
                scr_order.push_back(1'b0);
            end
        end
    end

    initial begin : watchdog
        #(CYCLE * WATCHDOG_CYCLES);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        seed         = 69753;
        value_errors = 0;
        other_errors = 0;
        scr_log      = 1'b0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_req    = '0;
        data_req     = '0;
        pd_cmd_ready = 1'b0;
        pd_rsp_valid = 1'b0;
        pd_rsp_rdata = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle_after_reset();
        tcm_write_readback();
        tcm_fetch_readback();
        scratch_round_robin();
        pd_bridge_access();
        repeat (2) @(posedge clk);
        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, other_errors, DUT.u_chk.fail_cnt);
        if (value_errors + other_errors + DUT.u_chk.fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : coreplex_tb

/* build.f */
+incdir+hdl
hdl/coreplex_pkg.sv
hdl/scratch_ram.sv
hdl/tcm_ram.sv
hdl/scratch_arbiter.sv
hdl/pd_icb_bridge.sv
hdl/rsp_merge.sv
hdl/coreplex_top.sv
tb/coreplex_chk.sv
tb/coreplex_tb.sv

/* Bender.yml */
package:
  name: coreplex

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/coreplex_pkg.sv
      - hdl/scratch_ram.sv
      - hdl/tcm_ram.sv
      - hdl/scratch_arbiter.sv
      - hdl/pd_icb_bridge.sv
      - hdl/rsp_merge.sv
      - hdl/coreplex_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/coreplex_chk.sv
      - tb/coreplex_tb.sv
